//--- logic/lrq_pkg.sv
`default_nettype none

package lrq_pkg;

  // queue and address geometry
  localparam int LRQ_ENTRY_SIZE = 4;
  localparam int LRQ_IDX_W      = $clog2(LRQ_ENTRY_SIZE);
  localparam int PADDR_W        = 32;
  localparam int LINE_OFS_W     = 6;  // 64-byte lines
  localparam int LINE_ADDR_W    = PADDR_W - LINE_OFS_W;

  // L2 command side
  localparam int L2_TAG_W            = 4;
  localparam logic L2_UPPER_TAG_L1D  = 1'b1;
  localparam int L2_TAG_FILLER_W     = L2_TAG_W - 1 - LRQ_IDX_W;
  localparam int L2_CMD_W            = 5;
  localparam logic [L2_CMD_W-1:0] L2_CMD_RD = 5'b00000;  // read, same code as M_XRD
  localparam int L2_CREDITS          = 2;
  localparam int L2_CREDIT_W         = $clog2(L2_CREDITS + 1);

  typedef logic [LRQ_IDX_W-1:0]      lrq_idx_t;
  typedef logic [LRQ_ENTRY_SIZE-1:0] lrq_oh_t;

  typedef struct packed {
    logic               valid;
    logic [PADDR_W-1:0] paddr;
  } load_req_t;

  typedef struct packed {
    logic    full;
    logic    conflict;
    lrq_oh_t index_oh;
  } load_rsp_t;

  typedef struct packed {
    logic               valid;
    logic               sent;
    logic [PADDR_W-1:0] paddr;  // always line aligned
  } lrq_entry_t;

  typedef struct packed {
    logic                valid;
    logic [L2_CMD_W-1:0] cmd;
    logic [PADDR_W-1:0]  addr;
    logic [L2_TAG_W-1:0] tag;
  } l2_req_t;

  typedef struct packed {
    logic                valid;
    logic [L2_TAG_W-1:0] tag;
  } l2_resp_t;

  typedef struct packed {
    logic    valid;
    lrq_oh_t resolve_index_oh;
  } lrq_resolve_t;

  // cache line number of a physical address
  function automatic logic [LINE_ADDR_W-1:0] line_addr(input logic [PADDR_W-1:0] paddr);
    return paddr[PADDR_W-1:LINE_OFS_W];
  endfunction

  function automatic logic [PADDR_W-1:0] line_align(input logic [PADDR_W-1:0] paddr);
    return {paddr[PADDR_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};
  endfunction

endpackage

`default_nettype wire

//--- logic/lrq_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module lrq_alloc (
  input  lrq_pkg::load_req_t  i_load,
  input  lrq_pkg::lrq_entry_t i_entries [lrq_pkg::LRQ_ENTRY_SIZE],
  output lrq_pkg::load_rsp_t  o_load_rsp,
  output lrq_pkg::lrq_oh_t    o_load_oh,
  output lrq_pkg::lrq_entry_t o_load_entry
);

  import lrq_pkg::*;

  lrq_oh_t w_valid_vec;
  lrq_oh_t w_hit_oh;
  lrq_oh_t w_free_oh;
  lrq_oh_t w_load_oh;
  logic    w_full;
  logic    w_conflict;
  logic    w_accept;

  // line compare against every valid entry
  always_comb begin
    for (int i = 0; i < LRQ_ENTRY_SIZE; i++) begin
      w_valid_vec[i] = i_entries[i].valid;
      w_hit_oh[i]    = i_load.valid & i_entries[i].valid &
                       (line_addr(i_entries[i].paddr) == line_addr(i_load.paddr));
    end
  end

  // lowest clear bit of the valid vector
  assign w_free_oh = ~w_valid_vec & (w_valid_vec + lrq_oh_t'(1));

  assign w_full     = &w_valid_vec;
  assign w_conflict = |w_hit_oh;  // at most one hit, lines are never duplicated
  assign w_accept   = i_load.valid & !w_full & !w_conflict;
  assign w_load_oh  = w_accept ? w_free_oh : '0;

  always_comb begin
    o_load_rsp.full     = w_full;
    o_load_rsp.conflict = w_conflict;
    o_load_rsp.index_oh = w_conflict ? w_hit_oh : w_load_oh;
  end

  assign o_load_oh = w_load_oh;

  // fresh entry image, waits for issue
  always_comb begin
    o_load_entry.valid = 1'b1;
    o_load_entry.sent  = 1'b0;
    o_load_entry.paddr = line_align(i_load.paddr);
  end

endmodule

`default_nettype wire

//--- logic/lrq_entry.sv
`timescale 1ns/1ps
`default_nettype none

module lrq_entry (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_load,
  input  lrq_pkg::lrq_entry_t i_load_entry,
  input  logic                i_sent,
  input  logic                i_clear,
  output lrq_pkg::lrq_entry_t o_entry
);

  import lrq_pkg::*;

  logic               r_valid;
  logic               r_sent;
  logic [PADDR_W-1:0] r_paddr;

  // load wins, load and clear never hit the same entry
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_valid <= 1'b0;
      r_sent  <= 1'b0;
    end else if (i_load) begin
      r_valid <= i_load_entry.valid;
      r_sent  <= i_load_entry.sent;
    end else if (i_clear) begin
      r_valid <= 1'b0;
      r_sent  <= 1'b0;
    end else if (i_sent) begin
      r_sent  <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_paddr <= i_load_entry.paddr;
    end
  end

  always_comb begin
    o_entry.valid = r_valid;
    o_entry.sent  = r_sent;
    o_entry.paddr = r_paddr;
  end

endmodule

`default_nettype wire

//--- logic/lrq_issue.sv
`timescale 1ns/1ps
`default_nettype none

module lrq_issue (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  lrq_pkg::lrq_entry_t i_entries [lrq_pkg::LRQ_ENTRY_SIZE],
  input  logic                i_l2_credit,
  output lrq_pkg::lrq_oh_t    o_sent_oh,
  output lrq_pkg::l2_req_t    o_l2_req
);

  import lrq_pkg::*;

  lrq_oh_t                w_pend_vec;
  lrq_oh_t                w_pick_oh;
  lrq_idx_t               w_pick_idx;
  logic                   w_req_vld;
  logic [L2_CREDIT_W-1:0] r_credit_cnt;

  always_comb begin
    for (int i = 0; i < LRQ_ENTRY_SIZE; i++) begin
      w_pend_vec[i] = i_entries[i].valid & !i_entries[i].sent;
    end
  end

  assign w_pick_oh = w_pend_vec & (~w_pend_vec + lrq_oh_t'(1));  // lowest pending

  always_comb begin
    w_pick_idx = '0;
    for (int i = 0; i < LRQ_ENTRY_SIZE; i++) begin
      if (w_pick_oh[i]) begin
        w_pick_idx = lrq_idx_t'(i);
      end
    end
  end

  assign w_req_vld = (|w_pend_vec) & (r_credit_cnt != '0);
  assign o_sent_oh = w_req_vld ? w_pick_oh : '0;

  always_comb begin
    o_l2_req.valid = w_req_vld;
    o_l2_req.cmd   = L2_CMD_RD;
    o_l2_req.addr  = i_entries[w_pick_idx].paddr;
    // marker, filler, entry index
    o_l2_req.tag   = {L2_UPPER_TAG_L1D, {L2_TAG_FILLER_W{1'b0}}, w_pick_idx};
  end

  // one credit per transfer, one back per pulse
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_credit_cnt <= L2_CREDIT_W'(L2_CREDITS);
    end else begin
      case ({w_req_vld, i_l2_credit})
        2'b10:   r_credit_cnt <= r_credit_cnt - 1'b1;
        2'b01:   r_credit_cnt <= r_credit_cnt + 1'b1;
        default: r_credit_cnt <= r_credit_cnt;  // none, or take and give together
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/lrq_refill.sv
`timescale 1ns/1ps
`default_nettype none

module lrq_refill (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  lrq_pkg::l2_resp_t     i_l2_resp,
  output lrq_pkg::lrq_oh_t      o_clear_oh,
  output lrq_pkg::lrq_resolve_t o_resolve
);

  import lrq_pkg::*;

  lrq_idx_t w_resp_idx;
  logic     w_hit;
  lrq_oh_t  w_clear_oh;
  logic     r_resolve_vld;
  lrq_oh_t  r_resolve_oh;

  assign w_resp_idx = i_l2_resp.tag[LRQ_IDX_W-1:0];
  // only responses carrying the load marker belong here
  assign w_hit      = i_l2_resp.valid & (i_l2_resp.tag[L2_TAG_W-1] == L2_UPPER_TAG_L1D);
  assign w_clear_oh = w_hit ? (lrq_oh_t'(1) << w_resp_idx) : '0;

  assign o_clear_oh = w_clear_oh;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_resolve_vld <= 1'b0;
    end else begin
      r_resolve_vld <= w_hit;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_hit) begin
      r_resolve_oh <= w_clear_oh;
    end
  end

  // freed entry reported to the load queue one cycle after the response
  always_comb begin
    o_resolve.valid            = r_resolve_vld;
    o_resolve.resolve_index_oh = r_resolve_oh;
  end

endmodule

`default_nettype wire

//--- logic/l1d_lrq_top.sv
`timescale 1ns/1ps
`default_nettype none

module l1d_lrq_top (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  lrq_pkg::load_req_t    i_load,
  output lrq_pkg::load_rsp_t    o_load_rsp,
  output lrq_pkg::l2_req_t      o_l2_req,
  input  logic                  i_l2_credit,
  input  lrq_pkg::l2_resp_t     i_l2_resp,
  output lrq_pkg::lrq_resolve_t o_resolve
);

  import lrq_pkg::*;

  lrq_entry_t w_entries [LRQ_ENTRY_SIZE];
  lrq_entry_t w_load_entry;
  lrq_oh_t    w_load_oh;
  lrq_oh_t    w_sent_oh;
  lrq_oh_t    w_clear_oh;

  lrq_alloc u_alloc (
    .i_load       (i_load),
    .i_entries    (w_entries),
    .o_load_rsp   (o_load_rsp),
    .o_load_oh    (w_load_oh),
    .o_load_entry (w_load_entry)
  );

  for (genvar e_idx = 0; e_idx < LRQ_ENTRY_SIZE; e_idx++) begin : entry_loop
    lrq_entry u_entry (
      .i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .i_load       (w_load_oh[e_idx]),
      .i_load_entry (w_load_entry),
      .i_sent       (w_sent_oh[e_idx]),
      .i_clear      (w_clear_oh[e_idx]),
      .o_entry      (w_entries[e_idx])
    );
  end

  lrq_issue u_issue (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_entries   (w_entries),
    .i_l2_credit (i_l2_credit),
    .o_sent_oh   (w_sent_oh),
    .o_l2_req    (o_l2_req)
  );

  lrq_refill u_refill (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_l2_resp  (i_l2_resp),
    .o_clear_oh (w_clear_oh),
    .o_resolve  (o_resolve)
  );

endmodule

`default_nettype wire

//--- tb/l1d_lrq_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module l1d_lrq_asserts (
  input logic                            i_clk,
  input logic                            i_rst_n,
  input logic [lrq_pkg::L2_CREDIT_W-1:0] i_credit_cnt,
  input logic                            i_l2_credit,
  input lrq_pkg::lrq_entry_t             i_entries [lrq_pkg::LRQ_ENTRY_SIZE],
  input lrq_pkg::l2_req_t                i_l2_req,
  input lrq_pkg::load_rsp_t              i_load_rsp,
  input lrq_pkg::lrq_resolve_t           i_resolve
);

  import lrq_pkg::*;

  int                     fail_cnt = 0;  // assertion failures so far
  logic [L2_CREDIT_W-1:0] r_port_credit;  // credits as seen on the L2 ports
  lrq_oh_t                w_sent_vec;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_port_credit <= L2_CREDIT_W'(L2_CREDITS);
    end else begin
      r_port_credit <= r_port_credit + L2_CREDIT_W'(i_l2_credit)
                       - L2_CREDIT_W'(i_l2_req.valid);
    end
  end

  always_comb begin
    for (int i = 0; i < LRQ_ENTRY_SIZE; i++) begin
      w_sent_vec[i] = i_entries[i].valid & i_entries[i].sent;
    end
  end

  a_credit_max : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_credit_cnt <= L2_CREDITS)
    else begin
      fail_cnt++;
      $error("credit count above its reset value");
    end

  // no transfer without a credit in hand
  a_req_credit : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_l2_req.valid |-> (r_port_credit != '0))
    else begin
      fail_cnt++;
      $error("L2 request valid with zero credits");
    end

  // the freed entry was waiting for its refill
  a_resolve_oh : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_resolve.valid |-> $onehot(i_resolve.resolve_index_oh) &&
                        ((i_resolve.resolve_index_oh & $past(w_sent_vec)) != '0))
    else begin
      fail_cnt++;
      $error("resolve index is not one-hot or names no sent entry");
    end

  a_index_oh : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $onehot0(i_load_rsp.index_oh))
    else begin
      fail_cnt++;
      $error("load reply index has more than one bit set");
    end

endmodule

bind l1d_lrq_top l1d_lrq_asserts u_asserts (
  .i_clk        (i_clk),
  .i_rst_n      (i_rst_n),
  .i_credit_cnt (u_issue.r_credit_cnt),
  .i_l2_credit  (i_l2_credit),
  .i_entries    (w_entries),
  .i_l2_req     (o_l2_req),
  .i_load_rsp   (o_load_rsp),
  .i_resolve    (o_resolve)
);

`default_nettype wire

//--- tb/tb_l1d_lrq.sv
`timescale 1ns/1ps
`default_nettype none

module tb_l1d_lrq;

  import lrq_pkg::*;

  localparam int          TABLE_LEN   = 48;
  localparam int          N_DIRECTED  = 13;
  localparam int          MAX_DELAY   = 8;
  localparam int          RST_CYCLES  = 16;
  localparam int          TIMEOUT_CYC = RST_CYCLES + TABLE_LEN * MAX_DELAY + 100;
  localparam logic [31:0] LCG_SEED    = 32'h06c9d0ab;
  localparam logic [31:0] POOL_BASE   = 32'h0000_2000;

  typedef struct packed {
    logic               offer;
    logic               hold;   // L2 model keeps its credits this cycle
    logic [3:0]         delay;  // cycles before the L2 may answer this load
    logic [PADDR_W-1:0] addr;
  } stim_row_t;

  logic         i_clk = 1'b0;
  logic         i_rst_n;
  load_req_t    i_load;
  load_rsp_t    o_load_rsp;
  l2_req_t      o_l2_req;
  logic         i_l2_credit;
  l2_resp_t     i_l2_resp;
  lrq_resolve_t o_resolve;

  stim_row_t          tbl [TABLE_LEN];
  logic               m_valid [LRQ_ENTRY_SIZE];
  logic               m_sent [LRQ_ENTRY_SIZE];
  logic [PADDR_W-1:0] m_addr [LRQ_ENTRY_SIZE];
  int                 m_delay [LRQ_ENTRY_SIZE];
  int                 m_credits;
  int                 owed;  // credits the L2 still has to hand back
  int                 l2_idx_q [$];
  int                 l2_due_q [$];
  lrq_resolve_t       exp_res;
  int                 cyc;
  int                 cycle_cnt = 0;
  int                 err_load = 0;
  int                 err_req = 0;
  int                 err_res = 0;
  int                 err_other = 0;
  int                 n_full = 0;
  int                 n_conflict = 0;
  int                 n_alloc = 0;
  int                 n_res_seen = 0;

  l1d_lrq_top u_l1d_lrq_top (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_load      (i_load),
    .o_load_rsp  (o_load_rsp),
    .o_l2_req    (o_l2_req),
    .i_l2_credit (i_l2_credit),
    .i_l2_resp   (i_l2_resp),
    .o_resolve   (o_resolve)
  );

  always #50 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("timeout: queue did not drain within %0d cycles", TIMEOUT_CYC);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [PADDR_W-1:0] line_of(input logic [PADDR_W-1:0] a);
    return a & ~((32'h1 << LINE_OFS_W) - 32'h1);
  endfunction

  // marker bit on top, entry index in the low bits
  function automatic logic [L2_TAG_W-1:0] tag_for(input int idx);
    return {L2_UPPER_TAG_L1D, (L2_TAG_W-1)'(idx)};
  endfunction

  function automatic stim_row_t make_row(input logic offer, input logic hold,
                                         input logic [3:0] delay, input logic [31:0] addr);
    stim_row_t r;
    r.offer = offer;
    r.hold  = hold;
    r.delay = delay;
    r.addr  = addr;
    return r;
  endfunction

  function automatic logic model_idle();
    logic busy;
    busy = exp_res.valid || (owed != 0);
    for (int i = 0; i < LRQ_ENTRY_SIZE; i++) begin
      busy = busy | m_valid[i];
    end
    return !busy;
  endfunction

  task automatic check_load_rsp(input load_rsp_t got, input load_rsp_t exp);
    if (got !== exp) begin
      err_load++;
      $display("error t=%0t o_load_rsp got %h exp %h", $time, got, exp);
    end
  endtask

  task automatic check_l2_req(input l2_req_t got, input l2_req_t exp);
    if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
      err_req++;
      $display("error t=%0t o_l2_req got %h exp %h", $time, got, exp);
    end
  endtask

  task automatic check_resolve(input lrq_resolve_t got, input lrq_resolve_t exp);
    if (got.valid !== exp.valid ||
        (exp.valid && got.resolve_index_oh !== exp.resolve_index_oh)) begin
      err_res++;
      $display("error t=%0t o_resolve got %h exp %h", $time, got, exp);
    end
  endtask

  task automatic fill_table();
    logic [31:0] r;
    r = LCG_SEED;
    // fill all four entries with credits held back, then overflow and conflict
    tbl[0]  = make_row(1'b1, 1'b1, 4'd6, 32'h0000_1000);
    tbl[1]  = make_row(1'b1, 1'b1, 4'd6, 32'h0000_1040);
    tbl[2]  = make_row(1'b1, 1'b1, 4'd6, 32'h0000_1080);
    tbl[3]  = make_row(1'b1, 1'b1, 4'd6, 32'h0000_10c0);
    tbl[4]  = make_row(1'b1, 1'b1, 4'd3, 32'h0000_1100);
    tbl[5]  = make_row(1'b1, 1'b1, 4'd3, 32'h0000_1008);
    tbl[6]  = make_row(1'b0, 1'b1, 4'd0, 32'h0);
    for (int n = 7; n < 12; n++) begin
      tbl[n] = make_row(1'b0, 1'b0, 4'd0, 32'h0);
    end
    tbl[12] = make_row(1'b1, 1'b0, 4'd2, 32'h0000_1140);  // reuses freed entry 0
    for (int n = N_DIRECTED; n < TABLE_LEN; n++) begin
      r = lcg_next(r);
      tbl[n] = make_row(r[31:30] != 2'b00, r[29:27] == 3'b000, {1'b0, r[26:24]},
                        POOL_BASE + (r[23:16] % 6) * 64 + r[13:8]);
    end
  endtask

  task automatic run_cycle(input stim_row_t row);
    load_rsp_t exp_rsp;
    l2_req_t   exp_req;
    lrq_oh_t   hit;
    logic      full;
    logic      accept;
    logic      credit_now;
    logic      resp_now;
    int        resp_idx;
    int        free_idx;
    int        pick;
    @(posedge i_clk);
    #1;
    i_load.valid = row.offer;
    i_load.paddr = row.addr;
    credit_now   = !row.hold && (owed > 0);
    if (credit_now) begin
      owed--;
    end
    i_l2_credit = credit_now;
    resp_now    = 1'b0;
    resp_idx    = 0;
    if (l2_idx_q.size() > 0 && l2_due_q[0] <= cyc) begin
      resp_now = 1'b1;
      resp_idx = l2_idx_q.pop_front();
      void'(l2_due_q.pop_front());
    end
    i_l2_resp.valid = resp_now;
    i_l2_resp.tag   = resp_now ? tag_for(resp_idx) : '0;

    @(negedge i_clk);
    full     = 1'b1;
    free_idx = -1;
    pick     = -1;
    hit      = '0;
    for (int i = LRQ_ENTRY_SIZE - 1; i >= 0; i--) begin
      if (!m_valid[i]) begin
        full     = 1'b0;
        free_idx = i;
      end else if (!m_sent[i]) begin
        pick = i;
      end
      hit[i] = row.offer && m_valid[i] && (line_of(m_addr[i]) == line_of(row.addr));
    end
    accept           = row.offer && !full && (hit == '0);
    exp_rsp.full     = full;
    exp_rsp.conflict = (hit != '0);
    exp_rsp.index_oh = (hit != '0) ? hit : (accept ? (lrq_oh_t'(1) << free_idx) : '0);
    exp_req          = '0;
    exp_req.valid    = (pick >= 0) && (m_credits > 0);
    if (exp_req.valid) begin
      exp_req.cmd  = L2_CMD_RD;
      exp_req.addr = m_addr[pick];
      exp_req.tag  = tag_for(pick);
    end

    check_load_rsp(o_load_rsp, exp_rsp);
    check_l2_req(o_l2_req, exp_req);
    check_resolve(o_resolve, exp_res);
    if (o_resolve.valid === 1'b1) begin
      n_res_seen++;
    end
    if (row.offer && o_load_rsp.full === 1'b1) begin
      n_full++;
    end
    if (o_load_rsp.conflict === 1'b1) begin
      n_conflict++;
    end

    // state after the coming edge
    exp_res.valid            = resp_now;
    exp_res.resolve_index_oh = resp_now ? (lrq_oh_t'(1) << resp_idx) : '0;
    if (resp_now) begin
      m_valid[resp_idx] = 1'b0;
      m_sent[resp_idx]  = 1'b0;
    end
    if (accept) begin
      m_valid[free_idx] = 1'b1;
      m_sent[free_idx]  = 1'b0;
      m_addr[free_idx]  = line_of(row.addr);
      m_delay[free_idx] = row.delay;
      n_alloc++;
    end
    if (exp_req.valid) begin
      m_sent[pick] = 1'b1;
      l2_idx_q.push_back(pick);
      l2_due_q.push_back(cyc + 1 + m_delay[pick]);
      owed++;
    end
    m_credits = m_credits + int'(credit_now) - int'(exp_req.valid);
    cyc++;
  endtask

  initial begin
    int assert_errs;
    int total;
    i_rst_n     = 1'b0;
    i_load      = '0;
    i_l2_credit = 1'b0;
    i_l2_resp   = '0;
    exp_res     = '0;
    m_credits   = L2_CREDITS;
    owed        = 0;
    cyc         = 0;
    for (int i = 0; i < LRQ_ENTRY_SIZE; i++) begin
      m_valid[i] = 1'b0;
      m_sent[i]  = 1'b0;
      m_addr[i]  = '0;
      m_delay[i] = 0;
    end
    fill_table();
    repeat (RST_CYCLES) @(posedge i_clk);
    #1 i_rst_n = 1'b1;

    for (int n = 0; n < TABLE_LEN; n++) begin
      run_cycle(tbl[n]);
    end
    while (!model_idle()) begin
      run_cycle(make_row(1'b0, 1'b0, 4'd0, 32'h0));
    end
    run_cycle(make_row(1'b0, 1'b0, 4'd0, 32'h0));

    if (n_full == 0) begin
      err_other++;
      $display("the load reply never showed a full queue");
    end
    if (n_conflict == 0) begin
      err_other++;
      $display("no load ever conflicted with an outstanding line");
    end
    if (n_res_seen != n_alloc) begin
      err_other++;
      $display("%0d loads were allocated but %0d resolves were seen", n_alloc, n_res_seen);
    end
    assert_errs = u_l1d_lrq_top.u_asserts.fail_cnt;
    total       = err_load + err_req + err_res + err_other + assert_errs;
    $display("errors: load_rsp=%0d l2_req=%0d resolve=%0d other=%0d assertions=%0d",
             err_load, err_req, err_res, err_other, assert_errs);
    if (total == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
logic/lrq_pkg.sv
logic/lrq_alloc.sv
logic/lrq_entry.sv
logic/lrq_issue.sv
logic/lrq_refill.sv
logic/l1d_lrq_top.sv
tb/l1d_lrq_asserts.sv
tb/tb_l1d_lrq.sv

//--- Bender.yml
package:
  name: l1d_lrq

sources:
  - logic/lrq_pkg.sv
  - logic/lrq_alloc.sv
  - logic/lrq_entry.sv
  - logic/lrq_issue.sv
  - logic/lrq_refill.sv
  - logic/l1d_lrq_top.sv
  - target: test
    files:
      - tb/l1d_lrq_asserts.sv
      - tb/tb_l1d_lrq.sv
